// File: src/l1_cache_pkg.sv
`default_nettype none

package l1_cache_pkg;

    // ========================================
    // widths
    // ========================================
    localparam int ADDR_WID  = 32;
    localparam int DATA_WID  = 32;
    localparam int INDEX_WID = 4;
    localparam int TAG_WID   = ADDR_WID - INDEX_WID - 2;
    localparam int LINE_WID  = TAG_WID + INDEX_WID;
    localparam int MESI_WID  = 2;
    localparam int CMD_WID   = 2;

    // ========================================
    // mesi line states
    // ========================================
    localparam logic [MESI_WID-1:0] MESI_I = 2'b00;
    localparam logic [MESI_WID-1:0] MESI_S = 2'b01;
    localparam logic [MESI_WID-1:0] MESI_E = 2'b10;
    localparam logic [MESI_WID-1:0] MESI_M = 2'b11;

    // next-level and snoop commands
    localparam logic [CMD_WID-1:0] CMD_RD  = 2'b00;
    localparam logic [CMD_WID-1:0] CMD_RDX = 2'b01;
    localparam logic [CMD_WID-1:0] CMD_INV = 2'b10;
    localparam logic [CMD_WID-1:0] CMD_WB  = 2'b11;

    // line number as put on the bus or split for the arrays
    typedef union packed {
        logic [LINE_WID-1:0] raw;
        struct packed {
            logic [TAG_WID-1:0]   tag;
            logic [INDEX_WID-1:0] index;
        } fields;
    } line_addr_u;

endpackage

`default_nettype wire

// File: src/l1_line_store.sv
`timescale 1ns/1ps
`default_nettype none

module l1_line_store (
    input  wire                                  clk,
    input  wire                                  rst_n,
    // cpu side port
    input  wire  [l1_cache_pkg::INDEX_WID-1:0]   proc_index,
    input  wire                                  proc_we,
    input  wire  [l1_cache_pkg::TAG_WID-1:0]     proc_tag_in,
    input  wire  [l1_cache_pkg::MESI_WID-1:0]    proc_state_in,
    input  wire  [l1_cache_pkg::DATA_WID-1:0]    proc_data_in,
    output logic [l1_cache_pkg::TAG_WID-1:0]     proc_tag,
    output logic [l1_cache_pkg::MESI_WID-1:0]    proc_state,
    output logic [l1_cache_pkg::DATA_WID-1:0]    proc_data,
    // snoop side port writes state only
    input  wire  [l1_cache_pkg::INDEX_WID-1:0]   snoop_index,
    input  wire                                  snoop_we,
    input  wire  [l1_cache_pkg::MESI_WID-1:0]    snoop_state_in,
    output logic [l1_cache_pkg::TAG_WID-1:0]     snoop_tag,
    output logic [l1_cache_pkg::MESI_WID-1:0]    snoop_state,
    output logic [l1_cache_pkg::DATA_WID-1:0]    snoop_data_out
);

    localparam int DEPTH = 2 ** l1_cache_pkg::INDEX_WID;

    logic [l1_cache_pkg::TAG_WID-1:0]  tag_mem   [DEPTH];
    logic [l1_cache_pkg::MESI_WID-1:0] state_mem [DEPTH];
    logic [l1_cache_pkg::DATA_WID-1:0] data_mem  [DEPTH];

    // snoop write last so it wins on the same index
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++)
                state_mem[i] <= l1_cache_pkg::MESI_I;
        end else begin
            if (proc_we)
                state_mem[proc_index] <= proc_state_in;
            if (snoop_we)
                state_mem[snoop_index] <= snoop_state_in;
        end
    end

    always_ff @(posedge clk) begin
        if (proc_we) begin
            tag_mem[proc_index]  <= proc_tag_in;
            data_mem[proc_index] <= proc_data_in;
        end
    end

    // registered reads return the old value on a same-cycle write
    always_ff @(posedge clk) begin
        proc_tag       <= tag_mem[proc_index];
        proc_state     <= state_mem[proc_index];
        proc_data      <= data_mem[proc_index];
        snoop_tag      <= tag_mem[snoop_index];
        snoop_state    <= state_mem[snoop_index];
        snoop_data_out <= data_mem[snoop_index];
    end

endmodule

`default_nettype wire

// File: src/l1_proc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module l1_proc_ctrl #(
    parameter int MEM_CREDITS = 2
) (
    input  wire                                  clk,
    input  wire                                  rst_n,
    // cpu request
    input  wire                                  cpu_rd,
    input  wire                                  cpu_wr,
    input  wire  [l1_cache_pkg::ADDR_WID-1:0]    cpu_addr,
    input  wire  [l1_cache_pkg::DATA_WID-1:0]    cpu_wdata,
    output logic                                 cpu_done,
    output logic [l1_cache_pkg::DATA_WID-1:0]    cpu_rdata,
    // store port
    output logic [l1_cache_pkg::INDEX_WID-1:0]   proc_index,
    output logic                                 proc_we,
    output logic [l1_cache_pkg::TAG_WID-1:0]     proc_tag_in,
    output logic [l1_cache_pkg::MESI_WID-1:0]    proc_state_in,
    output logic [l1_cache_pkg::DATA_WID-1:0]    proc_data_in,
    input  wire  [l1_cache_pkg::TAG_WID-1:0]     proc_tag,
    input  wire  [l1_cache_pkg::MESI_WID-1:0]    proc_state,
    input  wire  [l1_cache_pkg::DATA_WID-1:0]    proc_data,
    // next level
    output logic                                 mem_req_valid,
    output logic [l1_cache_pkg::CMD_WID-1:0]     mem_req_cmd,
    output logic [l1_cache_pkg::LINE_WID-1:0]    mem_req_line,
    output logic [l1_cache_pkg::DATA_WID-1:0]    mem_req_data,
    input  wire                                  mem_credit,
    input  wire                                  mem_resp_valid,
    input  wire  [l1_cache_pkg::DATA_WID-1:0]    mem_resp_data,
    input  wire                                  mem_resp_shared
);

    localparam int CNT_WID = $clog2(MEM_CREDITS + 1);

    localparam logic [2:0] ST_IDLE   = 3'd0;
    localparam logic [2:0] ST_LOOKUP = 3'd1;
    localparam logic [2:0] ST_WB     = 3'd2;
    localparam logic [2:0] ST_REQ    = 3'd3;
    localparam logic [2:0] ST_WAIT   = 3'd4;
    localparam logic [2:0] ST_DONE   = 3'd5;

    logic [2:0]                       state;
    logic [l1_cache_pkg::CMD_WID-1:0] req_cmd;
    logic [CNT_WID-1:0]               credits;
    l1_cache_pkg::line_addr_u         cpu_line;
    l1_cache_pkg::line_addr_u         victim_line;
    logic                             hit;
    logic                             can_issue;
    logic                             fill_rd;

    // index comes straight from the held cpu address
    assign cpu_line.raw = cpu_addr[l1_cache_pkg::ADDR_WID-1:2];
    assign proc_index   = cpu_line.fields.index;

    always_comb begin
        victim_line.fields.tag   = proc_tag;
        victim_line.fields.index = cpu_line.fields.index;
    end

    assign hit = (proc_state != l1_cache_pkg::MESI_I) && (proc_tag == cpu_line.fields.tag);

    // ========================================
    // next-level request channel
    // ========================================
    assign can_issue     = (credits != '0);
    assign mem_req_valid = ((state == ST_WB) || (state == ST_REQ)) && can_issue;
    assign mem_req_cmd   = (state == ST_WB) ? l1_cache_pkg::CMD_WB : req_cmd;
    assign mem_req_line  = (state == ST_WB) ? victim_line.raw : cpu_line.raw;
    assign mem_req_data  = (state == ST_WB) ? proc_data : cpu_wdata;

    always_ff @(posedge clk) begin
        if (!rst_n)
            credits <= CNT_WID'(MEM_CREDITS);
        else
            credits <= credits + CNT_WID'(mem_credit) - CNT_WID'(mem_req_valid);
    end

    // store writes on an E/M write hit or any response in WAIT
    assign fill_rd = (req_cmd == l1_cache_pkg::CMD_RD);

    always_comb begin
        proc_we       = 1'b0;
        proc_tag_in   = cpu_line.fields.tag;
        proc_state_in = l1_cache_pkg::MESI_M;
        proc_data_in  = cpu_wdata;
        if (state == ST_LOOKUP && cpu_wr && hit && proc_state != l1_cache_pkg::MESI_S)
            proc_we = 1'b1;
        if (state == ST_WAIT && mem_resp_valid) begin
            proc_we = 1'b1;
            if (fill_rd) begin
                proc_state_in = mem_resp_shared ? l1_cache_pkg::MESI_S : l1_cache_pkg::MESI_E;
                proc_data_in  = mem_resp_data;
            end
        end
    end

    // ========================================
    // request fsm
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            req_cmd  <= l1_cache_pkg::CMD_RD;
            cpu_done <= 1'b0;
        end else begin
            cpu_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (cpu_rd || cpu_wr)
                        state <= ST_LOOKUP;
                end
                ST_LOOKUP: begin
                    if (hit && (cpu_rd || proc_state != l1_cache_pkg::MESI_S)) begin
                        cpu_done <= 1'b1;
                        state    <= ST_DONE;
                    end else if (hit) begin
                        // write to a shared copy needs an upgrade first
                        req_cmd <= l1_cache_pkg::CMD_INV;
                        state   <= ST_REQ;
                    end else begin
                        req_cmd <= cpu_wr ? l1_cache_pkg::CMD_RDX : l1_cache_pkg::CMD_RD;
                        state   <= (proc_state == l1_cache_pkg::MESI_M) ? ST_WB : ST_REQ;
                    end
                end
                ST_WB: begin
                    if (can_issue)
                        state <= ST_REQ;
                end
                ST_REQ: begin
                    if (can_issue)
                        state <= ST_WAIT;
                end
                ST_WAIT: begin
                    // write-backs get no response so this is the fill or upgrade
                    if (mem_resp_valid) begin
                        cpu_done <= 1'b1;
                        state    <= ST_DONE;
                    end
                end
                default: begin
                    // cpu drops its request during this cycle
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_LOOKUP)
            cpu_rdata <= proc_data;
        else if (state == ST_WAIT && mem_resp_valid)
            cpu_rdata <= mem_resp_data;
    end

endmodule

`default_nettype wire

// File: src/l1_snoop_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module l1_snoop_ctrl (
    input  wire                                  clk,
    input  wire                                  rst_n,
    // snoop request
    input  wire                                  snoop_valid,
    input  wire  [l1_cache_pkg::CMD_WID-1:0]     snoop_cmd,
    input  wire  [l1_cache_pkg::LINE_WID-1:0]    snoop_line,
    // store port
    output logic [l1_cache_pkg::INDEX_WID-1:0]   snoop_index,
    output logic                                 snoop_we,
    output logic [l1_cache_pkg::MESI_WID-1:0]    snoop_state_in,
    input  wire  [l1_cache_pkg::TAG_WID-1:0]     snoop_tag,
    input  wire  [l1_cache_pkg::MESI_WID-1:0]    snoop_state,
    input  wire  [l1_cache_pkg::DATA_WID-1:0]    snoop_data_out,
    // response
    output logic                                 snoop_done,
    output logic                                 snoop_hit,
    output logic                                 snoop_data_valid,
    output logic [l1_cache_pkg::DATA_WID-1:0]    snoop_data
);

    l1_cache_pkg::line_addr_u           snp_line;
    logic                               pend;
    logic [l1_cache_pkg::CMD_WID-1:0]   cmd_q;
    logic [l1_cache_pkg::TAG_WID-1:0]   tag_q;
    logic [l1_cache_pkg::INDEX_WID-1:0] index_q;
    logic                               hit;

    assign snp_line.raw = snoop_line;

    // live index during the pulse and held index for the state write
    assign snoop_index = snoop_valid ? snp_line.fields.index : index_q;

    assign hit = pend && (snoop_state != l1_cache_pkg::MESI_I) && (snoop_tag == tag_q);

    // remote read leaves a shared copy and anything else kills it
    assign snoop_we       = hit;
    assign snoop_state_in = (cmd_q == l1_cache_pkg::CMD_RD) ? l1_cache_pkg::MESI_S
                                                            : l1_cache_pkg::MESI_I;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend             <= 1'b0;
            snoop_done       <= 1'b0;
            snoop_hit        <= 1'b0;
            snoop_data_valid <= 1'b0;
        end else begin
            pend             <= snoop_valid;
            snoop_done       <= pend;
            snoop_hit        <= hit;
            snoop_data_valid <= hit && (snoop_state == l1_cache_pkg::MESI_M) &&
                                (cmd_q != l1_cache_pkg::CMD_INV);
        end
    end

    always_ff @(posedge clk) begin
        if (snoop_valid) begin
            cmd_q   <= snoop_cmd;
            tag_q   <= snp_line.fields.tag;
            index_q <= snp_line.fields.index;
        end
        snoop_data <= snoop_data_out;
    end

endmodule

`default_nettype wire

// File: src/l1_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module l1_dcache #(
    parameter int MEM_CREDITS = 2
) (
    input  wire                                  clk,
    input  wire                                  rst_n,
    // cpu
    input  wire                                  cpu_rd,
    input  wire                                  cpu_wr,
    input  wire  [l1_cache_pkg::ADDR_WID-1:0]    cpu_addr,
    input  wire  [l1_cache_pkg::DATA_WID-1:0]    cpu_wdata,
    output logic                                 cpu_done,
    output logic [l1_cache_pkg::DATA_WID-1:0]    cpu_rdata,
    // next level
    output logic                                 mem_req_valid,
    output logic [l1_cache_pkg::CMD_WID-1:0]     mem_req_cmd,
    output logic [l1_cache_pkg::LINE_WID-1:0]    mem_req_line,
    output logic [l1_cache_pkg::DATA_WID-1:0]    mem_req_data,
    input  wire                                  mem_credit,
    input  wire                                  mem_resp_valid,
    input  wire  [l1_cache_pkg::DATA_WID-1:0]    mem_resp_data,
    input  wire                                  mem_resp_shared,
    // snoop
    input  wire                                  snoop_valid,
    input  wire  [l1_cache_pkg::CMD_WID-1:0]     snoop_cmd,
    input  wire  [l1_cache_pkg::LINE_WID-1:0]    snoop_line,
    output logic                                 snoop_done,
    output logic                                 snoop_hit,
    output logic                                 snoop_data_valid,
    output logic [l1_cache_pkg::DATA_WID-1:0]    snoop_data
);

    logic [l1_cache_pkg::INDEX_WID-1:0] proc_index;
    logic                               proc_we;
    logic [l1_cache_pkg::TAG_WID-1:0]   proc_tag_in;
    logic [l1_cache_pkg::MESI_WID-1:0]  proc_state_in;
    logic [l1_cache_pkg::DATA_WID-1:0]  proc_data_in;
    logic [l1_cache_pkg::TAG_WID-1:0]   proc_tag;
    logic [l1_cache_pkg::MESI_WID-1:0]  proc_state;
    logic [l1_cache_pkg::DATA_WID-1:0]  proc_data;

    logic [l1_cache_pkg::INDEX_WID-1:0] snoop_index;
    logic                               snoop_we;
    logic [l1_cache_pkg::MESI_WID-1:0]  snoop_state_in;
    logic [l1_cache_pkg::TAG_WID-1:0]   snoop_tag;
    logic [l1_cache_pkg::MESI_WID-1:0]  snoop_state;
    logic [l1_cache_pkg::DATA_WID-1:0]  snoop_data_out;

    l1_proc_ctrl #(
        .MEM_CREDITS (MEM_CREDITS)
    ) i_l1_proc_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .cpu_rd          (cpu_rd),
        .cpu_wr          (cpu_wr),
        .cpu_addr        (cpu_addr),
        .cpu_wdata       (cpu_wdata),
        .cpu_done        (cpu_done),
        .cpu_rdata       (cpu_rdata),
        .proc_index      (proc_index),
        .proc_we         (proc_we),
        .proc_tag_in     (proc_tag_in),
        .proc_state_in   (proc_state_in),
        .proc_data_in    (proc_data_in),
        .proc_tag        (proc_tag),
        .proc_state      (proc_state),
        .proc_data       (proc_data),
        .mem_req_valid   (mem_req_valid),
        .mem_req_cmd     (mem_req_cmd),
        .mem_req_line    (mem_req_line),
        .mem_req_data    (mem_req_data),
        .mem_credit      (mem_credit),
        .mem_resp_valid  (mem_resp_valid),
        .mem_resp_data   (mem_resp_data),
        .mem_resp_shared (mem_resp_shared)
    );

    l1_snoop_ctrl i_l1_snoop_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .snoop_valid      (snoop_valid),
        .snoop_cmd        (snoop_cmd),
        .snoop_line       (snoop_line),
        .snoop_index      (snoop_index),
        .snoop_we         (snoop_we),
        .snoop_state_in   (snoop_state_in),
        .snoop_tag        (snoop_tag),
        .snoop_state      (snoop_state),
        .snoop_data_out   (snoop_data_out),
        .snoop_done       (snoop_done),
        .snoop_hit        (snoop_hit),
        .snoop_data_valid (snoop_data_valid),
        .snoop_data       (snoop_data)
    );

    l1_line_store i_l1_line_store (
        .clk            (clk),
        .rst_n          (rst_n),
        .proc_index     (proc_index),
        .proc_we        (proc_we),
        .proc_tag_in    (proc_tag_in),
        .proc_state_in  (proc_state_in),
        .proc_data_in   (proc_data_in),
        .proc_tag       (proc_tag),
        .proc_state     (proc_state),
        .proc_data      (proc_data),
        .snoop_index    (snoop_index),
        .snoop_we       (snoop_we),
        .snoop_state_in (snoop_state_in),
        .snoop_tag      (snoop_tag),
        .snoop_state    (snoop_state),
        .snoop_data_out (snoop_data_out)
    );

endmodule

`default_nettype wire

// File: sim/l1_dcache_properties.sv
`timescale 1ns/1ps
`default_nettype none

module l1_dcache_properties #(
    parameter int MEM_CREDITS = 2
) (
    input wire clk,
    input wire rst_n,
    input wire mem_req_valid,
    input wire mem_credit,
    input wire snoop_valid,
    input wire snoop_done,
    input wire cpu_done
);

    int credits;

    // own copy of the credit count
    always_ff @(posedge clk) begin
        if (!rst_n)
            credits <= MEM_CREDITS;
        else
            credits <= credits + int'(mem_credit) - int'(mem_req_valid);
    end

    a_credit: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid |-> credits > 0)
        else $error("next-level request issued with no credit");

    a_snoop_done: assert property (@(posedge clk) disable iff (!rst_n)
        snoop_valid |-> ##2 snoop_done)
        else $error("snoop done not two cycles after snoop valid");

    a_cpu_done: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_done |=> !cpu_done)
        else $error("cpu done wider than one cycle");

endmodule

bind l1_dcache l1_dcache_properties #(.MEM_CREDITS(MEM_CREDITS)) i_l1_dcache_properties (
    .clk           (clk),
    .rst_n         (rst_n),
    .mem_req_valid (mem_req_valid),
    .mem_credit    (mem_credit),
    .snoop_valid   (snoop_valid),
    .snoop_done    (snoop_done),
    .cpu_done      (cpu_done)
);

`default_nettype wire

// File: sim/tb_l1_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_l1_dcache;

    localparam int MEM_CREDITS = 2;
    localparam int N_ITEMS     = 300;
    localparam int TIMEOUT     = 200 * N_ITEMS + 100;
    localparam int LW          = l1_cache_pkg::LINE_WID;
    localparam int IW          = l1_cache_pkg::INDEX_WID;
    localparam int TW          = l1_cache_pkg::TAG_WID;
    localparam logic [LW-1:0] LINE_BASE = 30'h3c1d0e0;

    logic        clk;
    logic        rst_n;
    logic        cpu_rd;
    logic        cpu_wr;
    logic [31:0] cpu_addr;
    logic [31:0] cpu_wdata;
    logic        cpu_done;
    logic [31:0] cpu_rdata;
    logic        mem_req_valid;
    logic [1:0]  mem_req_cmd;
    logic [LW-1:0] mem_req_line;
    logic [31:0] mem_req_data;
    logic        mem_credit;
    logic        mem_resp_valid;
    logic [31:0] mem_resp_data;
    logic        mem_resp_shared;
    logic        snoop_valid;
    logic [1:0]  snoop_cmd;
    logic [LW-1:0] snoop_line;
    logic        snoop_done;
    logic        snoop_hit;
    logic        snoop_data_valid;
    logic [31:0] snoop_data;

    integer seed = 32'hd8f9;
    int     cycle;
    logic   last_shared;

    // expected next-level requests in order
    logic [31:0] exp_cmd_q[$];
    logic [31:0] exp_line_q[$];
    logic [31:0] exp_data_q[$];
    logic [31:0] resp_data_q[$];
    logic        resp_shared_q[$];
    int          resp_due_q[$];
    int          credit_due_q[$];

    logic [31:0] mem    [logic [LW-1:0]];
    logic [31:0] golden [logic [LW-1:0]];
    logic [TW-1:0] m_tag   [2**IW];
    logic [1:0]    m_state [2**IW];
    logic [31:0]   m_data  [2**IW];

    l1_dcache #(.MEM_CREDITS(MEM_CREDITS)) i_l1_dcache (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] fill_pattern(input logic [LW-1:0] line);
        return {line, 2'b00} ^ 32'h9e37_79b9;
    endfunction

    function automatic logic [31:0] mem_value(input logic [LW-1:0] line);
        return mem.exists(line) ? mem[line] : fill_pattern(line);
    endfunction

    function automatic logic [31:0] golden_value(input logic [LW-1:0] line);
        return golden.exists(line) ? golden[line] : fill_pattern(line);
    endfunction

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_eq(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (expected !== actual)
            report_failure($sformatf("mismatch at %0t: %s expected %h got %h",
                                     $time, what, expected, actual));
    endtask

    task automatic push_request(input logic [1:0] cmd, input logic [LW-1:0] line,
                                input logic [31:0] data);
        exp_cmd_q.push_back(32'(cmd));
        exp_line_q.push_back(32'(line));
        exp_data_q.push_back(data);
    endtask

    // ========================================
    // next-level memory model
    // ========================================
    task automatic accept_request();
        logic [31:0] r;
        int delay;
        if (exp_cmd_q.size() == 0)
            report_failure("unexpected next-level request from the cache");
        check_eq("request cmd", exp_cmd_q.pop_front(), 32'(mem_req_cmd));
        check_eq("request line", exp_line_q.pop_front(), 32'(mem_req_line));
        r = $random(seed);
        if (mem_req_cmd == l1_cache_pkg::CMD_WB) begin
            check_eq("write-back data", exp_data_q.pop_front(), mem_req_data);
            mem[mem_req_line] = mem_req_data;
        end else begin
            void'(exp_data_q.pop_front());
            resp_data_q.push_back(mem_value(mem_req_line));
            resp_shared_q.push_back(r[0]);
            last_shared = r[0];
            resp_due_q.push_back(cycle + 1 + int'(r[3:1]));
        end
        // occasional long stretch without credits
        delay = 1 + int'(r[6:4]);
        if (r[9:7] == 3'd0)
            delay = delay + 20 + int'(r[14:10]);
        credit_due_q.push_back(cycle + delay);
    endtask

    always @(posedge clk) begin
        int k;
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT)
            report_failure($sformatf("timeout after %0d cycles", TIMEOUT));
        if (rst_n) begin
            if (mem_req_valid === 1'b1)
                accept_request();
            k = -1;
            foreach (credit_due_q[i])
                if (k < 0 && credit_due_q[i] <= cycle)
                    k = i;
            mem_credit <= (k >= 0);
            if (k >= 0)
                credit_due_q.delete(k);
            mem_resp_valid <= 1'b0;
            if (resp_due_q.size() != 0 && resp_due_q[0] <= cycle) begin
                mem_resp_valid  <= 1'b1;
                mem_resp_data   <= resp_data_q.pop_front();
                mem_resp_shared <= resp_shared_q.pop_front();
                void'(resp_due_q.pop_front());
            end
        end
    end

    // ========================================
    // cpu and snoop stimulus with reference model
    // ========================================
    task automatic cpu_access(input logic is_wr, input logic [LW-1:0] line,
                              input logic [31:0] wdata);
        logic [IW-1:0] idx;
        logic [TW-1:0] tag;
        logic          hit;
        logic [31:0]   expected;
        int            n;
        idx = line[IW-1:0];
        tag = line[LW-1:IW];
        hit = (m_state[idx] != l1_cache_pkg::MESI_I) && (m_tag[idx] == tag);
        if (!hit && m_state[idx] == l1_cache_pkg::MESI_M)
            push_request(l1_cache_pkg::CMD_WB, {m_tag[idx], idx}, m_data[idx]);
        if (!hit)
            push_request(is_wr ? l1_cache_pkg::CMD_RDX : l1_cache_pkg::CMD_RD, line, '0);
        else if (is_wr && m_state[idx] == l1_cache_pkg::MESI_S)
            push_request(l1_cache_pkg::CMD_INV, line, '0);
        expected = golden_value(line);
        @(posedge clk);
        cpu_rd    <= !is_wr;
        cpu_wr    <= is_wr;
        cpu_addr  <= {line, 2'b00};
        cpu_wdata <= wdata;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (cpu_done !== 1'b1);
        cpu_rd <= 1'b0;
        cpu_wr <= 1'b0;
        if (!is_wr)
            check_eq("read data", expected, cpu_rdata);
        // lookup plus response cycle after the sampling edge
        if (hit && !(is_wr && m_state[idx] == l1_cache_pkg::MESI_S))
            check_eq("hit latency", 32'd3, 32'(n));
        check_eq("requests still expected", 32'd0, 32'(exp_cmd_q.size()));
        if (is_wr) begin
            golden[line] = wdata;
            m_state[idx] = l1_cache_pkg::MESI_M;
            m_data[idx]  = wdata;
        end else if (!hit) begin
            m_state[idx] = last_shared ? l1_cache_pkg::MESI_S : l1_cache_pkg::MESI_E;
            m_data[idx]  = expected;
        end
        m_tag[idx] = tag;
    endtask

    task automatic snoop_access(input logic [LW-1:0] line, input logic [1:0] cmd_in);
        logic [IW-1:0] idx;
        logic          hit;
        logic          supply;
        logic [1:0]    cmd;
        int            n;
        idx = line[IW-1:0];
        hit = (m_state[idx] != l1_cache_pkg::MESI_I) && (m_tag[idx] == line[LW-1:IW]);
        cmd = cmd_in;
        // a remote upgrade implies nobody holds the line exclusively
        if (cmd == l1_cache_pkg::CMD_INV && hit && m_state[idx] != l1_cache_pkg::MESI_S)
            cmd = l1_cache_pkg::CMD_RD;
        supply = hit && m_state[idx] == l1_cache_pkg::MESI_M;
        @(posedge clk);
        snoop_valid <= 1'b1;
        snoop_cmd   <= cmd;
        snoop_line  <= line;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            snoop_valid <= 1'b0;
        end while (snoop_done !== 1'b1);
        check_eq("snoop latency", 32'd3, 32'(n));
        check_eq("snoop hit", 32'(hit), 32'(snoop_hit));
        check_eq("snoop data valid", 32'(supply), 32'(snoop_data_valid));
        if (supply) begin
            check_eq("snoop data", m_data[idx], snoop_data);
            mem[line] = m_data[idx];
        end
        if (hit)
            m_state[idx] = (cmd == l1_cache_pkg::CMD_RD) ? l1_cache_pkg::MESI_S
                                                        : l1_cache_pkg::MESI_I;
    endtask

    initial begin
        logic [31:0]   r;
        logic [LW-1:0] line;
        rst_n           = 1'b0;
        cpu_rd          = 1'b0;
        cpu_wr          = 1'b0;
        cpu_addr        = '0;
        cpu_wdata       = '0;
        mem_credit      = 1'b0;
        mem_resp_valid  = 1'b0;
        mem_resp_data   = '0;
        mem_resp_shared = 1'b0;
        snoop_valid     = 1'b0;
        snoop_cmd       = '0;
        snoop_line      = '0;
        cycle           = 0;
        last_shared     = 1'b0;
        for (int i = 0; i < 2**IW; i++)
            m_state[i] = l1_cache_pkg::MESI_I;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        for (int item = 0; item < N_ITEMS; item++) begin
            r    = $random(seed);
            line = LINE_BASE | {{(LW-5){1'b0}}, r[4:0]};
            if (r[7:5] < 3'd2)
                snoop_access(line, (r[9:8] == 2'd3) ? 2'd0 : r[9:8]);
            else
                cpu_access(r[10], line, $random(seed));
        end
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: l1_dcache.f
src/l1_cache_pkg.sv
src/l1_line_store.sv
src/l1_proc_ctrl.sv
src/l1_snoop_ctrl.sv
src/l1_dcache.sv
sim/l1_dcache_properties.sv
sim/tb_l1_dcache.sv

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_l1_dcache -f l1_dcache.f \
    --Mdir obj_dir -o tb_l1_dcache

./obj_dir/tb_l1_dcache | tee sim.log

if grep -q "Verification passed" sim.log; then
    exit 0
fi
exit 1
